// File: verilog/video_params.svh
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// 640x480 at 60 Hz, 25.175 MHz pixel clock

// horizontal timing, in pixels
`define H_VISIBLE       640
`define H_FRONT_PORCH   16
`define H_SYNC_PULSE    96
`define H_BACK_PORCH    48

// vertical timing, in lines
`define V_VISIBLE       480
`define V_FRONT_PORCH   10
`define V_SYNC_PULSE    2
`define V_BACK_PORCH    33

// offscreen pixels come before the visible part of a line
`define H_OFFSCREEN     (`H_FRONT_PORCH + `H_SYNC_PULSE + `H_BACK_PORCH)

`define H_TOTAL         (`H_OFFSCREEN + `H_VISIBLE)
`define V_TOTAL         (`V_VISIBLE + `V_FRONT_PORCH + `V_SYNC_PULSE + `V_BACK_PORCH)

// active level of each sync, both negative for this mode
`define H_SYNC_POL      1'b0
`define V_SYNC_POL      1'b0

// border colour after reset, dark grey so a live chip shows something
`define BORDER_RESET    8'h08

`endif

// File: verilog/video_timing_pkg.sv
package video_timing_pkg;

    // horizontal counter and pixel x, covers 0..H_TOTAL-1
    typedef logic [9:0] hres_t;

    // vertical counter and pixel y, covers 0..V_TOTAL-1
    typedef logic [9:0] vres_t;

    // one state per part of a line or frame
    // the order matters, each state advances to the next by adding one
    typedef enum logic [1:0] {
        PRE_SYNC    = 2'b00,    // front porch
        SYNC        = 2'b01,    // sync pulse
        POST_SYNC   = 2'b10,    // back porch
        VISIBLE     = 2'b11     // active video
    } sync_state_e;

endpackage

// File: verilog/video_regs_pkg.sv
package video_regs_pkg;

    typedef logic [15:0] word_t;        // register bus word
    typedef logic [7:0]  color_t;       // palette colour index
    typedef logic [4:0]  reg_num_t;     // register number on the bus

    // register map, gaps read as zero
    typedef enum logic [4:0] {
        XR_VID_CTRL     = 5'd0,         // border colour, interrupt status
        XR_VID_TOP      = 5'd4,         // window top line
        XR_VID_BOTTOM   = 5'd5,         // window bottom line, exclusive
        XR_VID_LEFT     = 5'd6,         // window left pixel
        XR_VID_RIGHT    = 5'd7,         // window right pixel, exclusive
        XR_SCANLINE     = 5'd8,         // read only
        XR_VID_HSIZE    = 5'd10,        // read only
        XR_VID_VSIZE    = 5'd11,        // read only
        XR_PA_GFX_CTRL  = 5'd16         // playfield A colour base and blank
    } xr_reg_e;

    // bit 3 is the vertical blank interrupt
    typedef logic [3:0] intr_t;

endpackage

// File: verilog/video_sync_gen.sv
`default_nettype none
`timescale 1ns/1ps

`include "video_params.svh"

module video_sync_gen (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    output      logic                       line_end_o,     // last visible pixel of a line
    output      logic                       vblank_start_o, // last visible pixel of a frame
    output      logic                       h_visible_o,
    output      logic                       v_visible_o,
    output      video_timing_pkg::vres_t    v_count_o,
    output      video_timing_pkg::hres_t    pix_x_o,        // pixel shown after the next edge
    output      video_timing_pkg::vres_t    pix_y_o,
    output      logic                       pix_de_o,
    output      logic                       hsync_o,
    output      logic                       vsync_o,
    output      logic                       dv_de_o
);
    import video_timing_pkg::*;

    sync_state_e    h_state;
    sync_state_e    h_state_next;
    hres_t          h_count;
    hres_t          h_count_next;
    hres_t          h_end;              // last count of the current h state

    sync_state_e    v_state;
    sync_state_e    v_state_next;
    vres_t          v_count;
    vres_t          v_count_next;
    vres_t          v_end;              // last line of the current v state

    logic           frame_end;          // last pixel of the final back porch line

    // horizontally the offscreen pixels come first, then the visible ones
    always_comb begin
        case (h_state)
            PRE_SYNC:   h_end = hres_t'(`H_FRONT_PORCH - 1);
            SYNC:       h_end = hres_t'(`H_FRONT_PORCH + `H_SYNC_PULSE - 1);
            POST_SYNC:  h_end = hres_t'(`H_OFFSCREEN - 1);
            VISIBLE:    h_end = hres_t'(`H_TOTAL - 1);
        endcase
    end

    // vertically the visible lines come first, blanking after them
    always_comb begin
        case (v_state)
            PRE_SYNC:   v_end = vres_t'(`V_VISIBLE + `V_FRONT_PORCH - 1);
            SYNC:       v_end = vres_t'(`V_VISIBLE + `V_FRONT_PORCH + `V_SYNC_PULSE - 1);
            POST_SYNC:  v_end = vres_t'(`V_TOTAL - 1);
            VISIBLE:    v_end = vres_t'(`V_VISIBLE - 1);
        endcase
    end

    always_comb h_state_next = (h_count == h_end) ? sync_state_e'(h_state + 2'd1) : h_state;

    // vertical state only moves at the end of a line
    always_comb begin
        v_state_next = v_state;
        if (line_end_o && v_count == v_end) begin
            v_state_next = sync_state_e'(v_state + 2'd1);
        end
    end

    always_comb line_end_o      = (h_state == VISIBLE) && (h_state_next == PRE_SYNC);
    always_comb vblank_start_o  = line_end_o && (v_state == VISIBLE) && (v_state_next == PRE_SYNC);
    always_comb frame_end       = line_end_o && (v_state == POST_SYNC) && (v_state_next == VISIBLE);

    always_comb begin
        h_count_next = h_count + 1'b1;
        v_count_next = v_count;
        if (line_end_o) begin
            h_count_next = '0;
            v_count_next = frame_end ? '0 : v_count + 1'b1;
        end
    end

    always_comb h_visible_o = (h_state == VISIBLE);
    always_comb v_visible_o = (v_state == VISIBLE);
    always_comb v_count_o   = v_count;

    // next-state pixel, lines up with the registered outputs below
    always_comb pix_x_o     = h_count_next - hres_t'(`H_OFFSCREEN);
    always_comb pix_y_o     = v_count_next;
    always_comb pix_de_o    = (h_state_next == VISIBLE) && (v_state_next == VISIBLE);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= PRE_SYNC;
            v_state <= PRE_SYNC;
            h_count <= '0;
            v_count <= '0;
            hsync_o <= ~`H_SYNC_POL;                // idle level
            vsync_o <= ~`V_SYNC_POL;
            dv_de_o <= 1'b0;
        end else begin
            h_state <= h_state_next;
            v_state <= v_state_next;
            h_count <= h_count_next;
            v_count <= v_count_next;
            hsync_o <= (h_state_next == SYNC) ? `H_SYNC_POL : ~`H_SYNC_POL;
            vsync_o <= (v_state_next == SYNC) ? `V_SYNC_POL : ~`V_SYNC_POL;
            dv_de_o <= pix_de_o;
        end
    end

endmodule

`default_nettype wire

// File: verilog/video_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "video_params.svh"

module video_regs (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       wb_cyc_i,
    input  wire logic                       wb_stb_i,
    input  wire logic                       wb_we_i,
    input  wire video_regs_pkg::reg_num_t   wb_adr_i,
    input  wire video_regs_pkg::word_t      wb_dat_i,
    output      logic                       wb_ack_o,
    output      video_regs_pkg::word_t      wb_dat_o,
    input  wire video_regs_pkg::intr_t      intr_status_i,  // pending interrupts, read back only
    output      video_regs_pkg::intr_t      intr_o,         // one cycle interrupt pulses
    input  wire logic                       vblank_start_i,
    input  wire logic                       h_visible_i,
    input  wire logic                       v_visible_i,
    input  wire video_timing_pkg::vres_t    v_count_i,
    output      video_regs_pkg::color_t     border_color_o,
    output      video_timing_pkg::vres_t    vid_top_o,
    output      video_timing_pkg::vres_t    vid_bottom_o,
    output      video_timing_pkg::hres_t    vid_left_o,
    output      video_timing_pkg::hres_t    vid_right_o,
    output      video_regs_pkg::color_t     pa_colorbase_o,
    output      logic                       pa_blank_o
);
    import video_timing_pkg::*;
    import video_regs_pkg::*;

    logic   bus_req;            // new cycle seen, ack goes out on this edge
    logic   wr_en;
    word_t  rd_data;

    always_comb bus_req = wb_cyc_i && wb_stb_i && !wb_ack_o;
    always_comb wr_en   = bus_req && wb_we_i;

    // single cycle ack, dropped again even if the host keeps stb high
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= bus_req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            border_color_o  <= `BORDER_RESET;
            vid_top_o       <= '0;
            vid_bottom_o    <= vres_t'(`V_VISIBLE);
            vid_left_o      <= '0;
            vid_right_o     <= hres_t'(`H_VISIBLE);
            pa_colorbase_o  <= '0;
            pa_blank_o      <= 1'b1;                // playfield A starts blanked
            intr_o          <= '0;
        end else begin
            intr_o <= '0;
            if (wr_en) begin
                case (wb_adr_i)
                    XR_VID_CTRL: begin
                        border_color_o  <= wb_dat_i[15:8];
                        intr_o          <= wb_dat_i[3:0];   // software triggered interrupts
                    end
                    XR_VID_TOP: begin
                        vid_top_o <= wb_dat_i[9:0];
                    end
                    XR_VID_BOTTOM: begin
                        vid_bottom_o <= wb_dat_i[9:0];
                    end
                    XR_VID_LEFT: begin
                        vid_left_o <= wb_dat_i[9:0];
                    end
                    XR_VID_RIGHT: begin
                        vid_right_o <= wb_dat_i[9:0];
                    end
                    XR_PA_GFX_CTRL: begin
                        pa_colorbase_o  <= wb_dat_i[15:8];
                        pa_blank_o      <= wb_dat_i[7];
                    end
                    default: begin
                    end
                endcase
            end
            // vertical blank interrupt, once per frame
            if (vblank_start_i) begin
                intr_o[3] <= 1'b1;
            end
        end
    end

    always_comb begin
        case (wb_adr_i)
            XR_VID_CTRL:    rd_data = {border_color_o, 4'b0000, intr_status_i};
            XR_VID_TOP:     rd_data = word_t'(vid_top_o);
            XR_VID_BOTTOM:  rd_data = word_t'(vid_bottom_o);
            XR_VID_LEFT:    rd_data = word_t'(vid_left_o);
            XR_VID_RIGHT:   rd_data = word_t'(vid_right_o);
            XR_SCANLINE:    rd_data = {~v_visible_i, ~h_visible_i, 4'b0000, v_count_i};
            XR_VID_HSIZE:   rd_data = word_t'(`H_VISIBLE);
            XR_VID_VSIZE:   rd_data = word_t'(`V_VISIBLE);
            XR_PA_GFX_CTRL: rd_data = {pa_colorbase_o, pa_blank_o, 7'b0000000};
            default:        rd_data = '0;       // unmapped numbers
        endcase
    end

    // address is held by the host, so this is valid in the ack cycle
    always_ff @(posedge clk) begin
        wb_dat_o <= rd_data;
    end

endmodule

`default_nettype wire

// File: verilog/video_window.sv
`default_nettype none
`timescale 1ns/1ps

module video_window (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire video_timing_pkg::hres_t    pix_x_i,
    input  wire video_timing_pkg::vres_t    pix_y_i,
    input  wire logic                       pix_de_i,
    input  wire video_regs_pkg::color_t     border_color_i,
    input  wire video_timing_pkg::vres_t    vid_top_i,
    input  wire video_timing_pkg::vres_t    vid_bottom_i,
    input  wire video_timing_pkg::hres_t    vid_left_i,
    input  wire video_timing_pkg::hres_t    vid_right_i,
    input  wire video_regs_pkg::color_t     pa_colorbase_i,
    input  wire logic                       pa_blank_i,
    output      video_regs_pkg::color_t     color_index_o
);
    import video_regs_pkg::*;

    logic   in_window;
    color_t color_next;

    // right and bottom bounds are exclusive
    always_comb in_window = (pix_x_i >= vid_left_i) && (pix_x_i < vid_right_i) &&
                            (pix_y_i >= vid_top_i) && (pix_y_i < vid_bottom_i);

    always_comb begin
        if (!pix_de_i) begin
            color_next = '0;                        // blanking
        end else if (!in_window || pa_blank_i) begin
            color_next = border_color_i;
        end else begin
            color_next = pa_colorbase_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            color_index_o <= '0;
        end else begin
            color_index_o <= color_next;            // same edge as dv_de_o
        end
    end

endmodule

`default_nettype wire

// File: verilog/video_gen.sv
`default_nettype none
`timescale 1ns/1ps

module video_gen (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       wb_cyc_i,
    input  wire logic                       wb_stb_i,
    input  wire logic                       wb_we_i,
    input  wire video_regs_pkg::reg_num_t   wb_adr_i,
    input  wire video_regs_pkg::word_t      wb_dat_i,
    output      logic                       wb_ack_o,
    output      video_regs_pkg::word_t      wb_dat_o,
    input  wire video_regs_pkg::intr_t      intr_status_i,
    output      video_regs_pkg::intr_t      intr_o,
    output      logic                       hsync_o,
    output      logic                       vsync_o,
    output      logic                       dv_de_o,
    output      video_regs_pkg::color_t     color_index_o
);
    import video_timing_pkg::*;
    import video_regs_pkg::*;

    logic   vblank_start;
    logic   h_visible;
    logic   v_visible;
    vres_t  v_count;

    hres_t  pix_x;
    vres_t  pix_y;
    logic   pix_de;

    color_t border_color;
    vres_t  vid_top;
    vres_t  vid_bottom;
    hres_t  vid_left;
    hres_t  vid_right;
    color_t pa_colorbase;
    logic   pa_blank;

    video_sync_gen sync0 (
        .clk(clk),
        .reset_i(reset_i),
        .line_end_o(),                  // per line strobe, no consumer here
        .vblank_start_o(vblank_start),
        .h_visible_o(h_visible),
        .v_visible_o(v_visible),
        .v_count_o(v_count),
        .pix_x_o(pix_x),
        .pix_y_o(pix_y),
        .pix_de_o(pix_de),
        .hsync_o(hsync_o),
        .vsync_o(vsync_o),
        .dv_de_o(dv_de_o)
    );

    video_regs regs0 (
        .clk(clk),
        .reset_i(reset_i),
        .wb_cyc_i(wb_cyc_i),
        .wb_stb_i(wb_stb_i),
        .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i),
        .wb_dat_i(wb_dat_i),
        .wb_ack_o(wb_ack_o),
        .wb_dat_o(wb_dat_o),
        .intr_status_i(intr_status_i),
        .intr_o(intr_o),
        .vblank_start_i(vblank_start),
        .h_visible_i(h_visible),
        .v_visible_i(v_visible),
        .v_count_i(v_count),
        .border_color_o(border_color),
        .vid_top_o(vid_top),
        .vid_bottom_o(vid_bottom),
        .vid_left_o(vid_left),
        .vid_right_o(vid_right),
        .pa_colorbase_o(pa_colorbase),
        .pa_blank_o(pa_blank)
    );

    video_window window0 (
        .clk(clk),
        .reset_i(reset_i),
        .pix_x_i(pix_x),
        .pix_y_i(pix_y),
        .pix_de_i(pix_de),
        .border_color_i(border_color),
        .vid_top_i(vid_top),
        .vid_bottom_i(vid_bottom),
        .vid_left_i(vid_left),
        .vid_right_i(vid_right),
        .pa_colorbase_i(pa_colorbase),
        .pa_blank_i(pa_blank),
        .color_index_o(color_index_o)
    );

endmodule

`default_nettype wire

// File: sim/video_gen_tb.sv
`timescale 1ns/1ps

`include "video_params.svh"

module video_gen_tb;
    import video_regs_pkg::*;

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int WAIT_LIMIT   = 3 * FRAME_CYCLES;     // first frame after reset runs long
    localparam int ACK_LIMIT    = 16;
    localparam int SIG_DE       = 0;
    localparam int SIG_HSYNC    = 1;
    localparam int SIG_VSYNC    = 2;
    localparam int SIG_VBI      = 3;

    logic       clk;
    logic       reset_i;
    logic       wb_cyc_i;
    logic       wb_stb_i;
    logic       wb_we_i;
    reg_num_t   wb_adr_i;
    word_t      wb_dat_i;
    logic       wb_ack_o;
    word_t      wb_dat_o;
    intr_t      intr_status_i;
    intr_t      intr_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;
    color_t     color_index_o;

    integer     seed;
    color_t     m_border;                   // copy of the register state
    logic [9:0] m_top;
    logic [9:0] m_bottom;
    logic [9:0] m_left;
    logic [9:0] m_right;
    color_t     m_colorbase;
    logic       m_blank;

    logic       check_en = 1'b0;
    int         pixels = 0;
    int         px = 0;
    int         py = 0;
    logic       de_last = 1'b0;
    string      pixel_test = "pixel";

    reg_num_t   writable [6] = '{XR_VID_CTRL, XR_VID_TOP, XR_VID_BOTTOM,
                                 XR_VID_LEFT, XR_VID_RIGHT, XR_PA_GFX_CTRL};

    video_gen dut0 (
        .clk(clk),
        .reset_i(reset_i),
        .wb_cyc_i(wb_cyc_i),
        .wb_stb_i(wb_stb_i),
        .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i),
        .wb_dat_i(wb_dat_i),
        .wb_ack_o(wb_ack_o),
        .wb_dat_o(wb_dat_o),
        .intr_status_i(intr_status_i),
        .intr_o(intr_o),
        .hsync_o(hsync_o),
        .vsync_o(vsync_o),
        .dv_de_o(dv_de_o),
        .color_index_o(color_index_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            stop_run($sformatf("Fail %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    // one classic cycle from a falling edge to the falling edge that sees ack
    task automatic bus_cycle(input logic we, input reg_num_t adr, input word_t wdata,
                             output word_t rdata);
        int n;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack_o && n < ACK_LIMIT);
        if (!wb_ack_o) begin
            stop_run("no acknowledge from register bus");
        end
        rdata    = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input reg_num_t adr, input word_t data);
        word_t unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input reg_num_t adr, output word_t data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    task automatic load_reset_model;
        m_border    = `BORDER_RESET;
        m_top       = '0;
        m_bottom    = `V_VISIBLE;
        m_left      = '0;
        m_right     = `H_VISIBLE;
        m_colorbase = '0;
        m_blank     = 1'b1;
    endtask

    task automatic apply_write(input reg_num_t adr, input word_t data);
        case (adr)
            XR_VID_CTRL:    m_border = data[15:8];
            XR_VID_TOP:     m_top = data[9:0];
            XR_VID_BOTTOM:  m_bottom = data[9:0];
            XR_VID_LEFT:    m_left = data[9:0];
            XR_VID_RIGHT:   m_right = data[9:0];
            XR_PA_GFX_CTRL: begin
                m_colorbase = data[15:8];
                m_blank     = data[7];
            end
            default: ;
        endcase
    endtask

    task automatic write_and_track(input reg_num_t adr, input word_t data);
        wb_write(adr, data);
        apply_write(adr, data);
    endtask

    function automatic logic is_named(input reg_num_t adr);
        case (adr)
            XR_VID_CTRL, XR_VID_TOP, XR_VID_BOTTOM, XR_VID_LEFT, XR_VID_RIGHT,
            XR_SCANLINE, XR_VID_HSIZE, XR_VID_VSIZE, XR_PA_GFX_CTRL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // readback format of each register except scanline
    function automatic word_t expected_read(input reg_num_t adr);
        case (adr)
            XR_VID_CTRL:    return {m_border, 4'b0000, intr_status_i};
            XR_VID_TOP:     return {6'b0, m_top};
            XR_VID_BOTTOM:  return {6'b0, m_bottom};
            XR_VID_LEFT:    return {6'b0, m_left};
            XR_VID_RIGHT:   return {6'b0, m_right};
            XR_VID_HSIZE:   return 16'd640;
            XR_VID_VSIZE:   return 16'd480;
            XR_PA_GFX_CTRL: return {m_colorbase, m_blank, 7'b0000000};
            default:        return '0;
        endcase
    endfunction

    function automatic color_t expected_color(input int x, input int y);
        if (x >= m_left && x < m_right && y >= m_top && y < m_bottom && !m_blank) begin
            return m_colorbase;
        end
        return m_border;
    endfunction

    function automatic logic probe(input int which);
        case (which)
            SIG_DE:     return dv_de_o;
            SIG_HSYNC:  return hsync_o == `H_SYNC_POL;
            SIG_VSYNC:  return vsync_o == `V_SYNC_POL;
            default:    return intr_o[3];
        endcase
    endfunction

    // returns on the first falling edge where the signal has just become active
    task automatic wait_for_start(input int which, input string what);
        int n;
        logic was;
        was = probe(which);
        n = 0;
        while (!(probe(which) && !was) && n < WAIT_LIMIT) begin
            was = probe(which);
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            stop_run($sformatf("timed out waiting for %s", what));
        end
    endtask

    task automatic measure_high(input int which, input string what, output int n);
        n = 0;
        while (probe(which) && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (n >= WAIT_LIMIT) begin
            stop_run($sformatf("%s never went inactive", what));
        end
    endtask

    task automatic check_line_timing;
        int high;
        int low;
        wait_for_start(SIG_HSYNC, "hsync");
        measure_high(SIG_HSYNC, "hsync", high);
        check("hsync width", `H_SYNC_PULSE, high);
        wait_for_start(SIG_DE, "display enable");
        measure_high(SIG_DE, "display enable", high);
        check("display enable width", `H_VISIBLE, high);
        low = 0;
        while (!dv_de_o && low < WAIT_LIMIT) begin
            low++;
            @(negedge clk);
        end
        if (!dv_de_o) begin
            stop_run("display enable did not return on the next line");
        end
        check("display enable period", `H_TOTAL, high + low);
    endtask

    task automatic check_frame_timing;
        int cycles;
        int de_cycles;
        int vs_cycles;
        wait_for_start(SIG_VBI, "vertical blank interrupt");
        cycles    = 0;
        de_cycles = 0;
        vs_cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (dv_de_o) de_cycles++;
            if (probe(SIG_VSYNC)) vs_cycles++;
        end while (!intr_o[3] && cycles < WAIT_LIMIT);
        if (!intr_o[3]) begin
            stop_run("second vertical blank interrupt never came");
        end
        check("frame cycles", FRAME_CYCLES, cycles);
        check("display enable per frame", `H_VISIBLE * `V_VISIBLE, de_cycles);
        check("vsync per frame", `V_SYNC_PULSE * `H_TOTAL, vs_cycles);
    endtask

    // compares every visible pixel of one whole frame
    task automatic check_window_frame(input string name);
        wait_for_start(SIG_VSYNC, "vsync");
        pixel_test = name;
        pixels     = 0;
        check_en   = 1'b1;
        wait_for_start(SIG_VSYNC, "vsync");
        check_en   = 1'b0;
        check({name, " count"}, `H_VISIBLE * `V_VISIBLE, pixels);
    endtask

    // pixel position follows dv_de_o and y restarts during vsync
    always @(negedge clk) begin
        if (check_en && !dv_de_o) begin
            check({pixel_test, " blanking"}, 0, color_index_o);
        end
        if (probe(SIG_VSYNC)) begin
            px = 0;
            py = 0;
        end else if (dv_de_o) begin
            if (!de_last) px = 0;
            if (check_en) begin
                check(pixel_test, expected_color(px, py), color_index_o);
                pixels++;
            end
            px++;
        end else if (de_last) begin
            py++;
        end
        de_last = dv_de_o;
    end

    initial begin
        word_t  rdata;
        word_t  wdata;
        color_t cb;
        seed          = 32'h648b;
        reset_i       = 1'b1;
        wb_cyc_i      = 1'b0;
        wb_stb_i      = 1'b0;
        wb_we_i       = 1'b0;
        wb_adr_i      = '0;
        wb_dat_i      = '0;
        intr_status_i = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        load_reset_model();
        for (int a = 0; a < 32; a++) begin
            if (is_named(reg_num_t'(a)) && reg_num_t'(a) != XR_SCANLINE) begin
                wb_read(reg_num_t'(a), rdata);
                check($sformatf("reset value of register %0d", a),
                      expected_read(reg_num_t'(a)), rdata);
            end
        end
        foreach (writable[i]) begin
            wdata = $random(seed);
            write_and_track(writable[i], wdata);
            wb_read(writable[i], rdata);
            check($sformatf("readback of register %0d", writable[i]),
                  expected_read(writable[i]), rdata);
        end
        for (int a = 0; a < 32; a++) begin
            if (!is_named(reg_num_t'(a))) begin
                wb_write(reg_num_t'(a), $random(seed));     // must be ignored
                wb_read(reg_num_t'(a), rdata);
                check($sformatf("unknown register %0d", a), 0, rdata);
            end
        end

        check_line_timing();
        check_frame_timing();

        // still at the interrupt so the bus read falls into the first blank line
        wb_read(XR_SCANLINE, rdata);
        check("scanline blank flags", 2'b11, rdata[15:14]);
        check("scanline line number", `V_VISIBLE, rdata[9:0]);
        wdata = $random(seed);
        write_and_track(XR_VID_CTRL, wdata);
        check("write interrupt pulse", wdata[3:0], intr_o);
        @(negedge clk);
        check("interrupt pulse length", 0, intr_o);
        intr_status_i = $random(seed);
        wb_read(XR_VID_CTRL, rdata);
        check("control status readback", expected_read(XR_VID_CTRL), rdata);

        wdata = {8'($random(seed)), 8'h00};
        write_and_track(XR_VID_CTRL, wdata);
        write_and_track(XR_VID_LEFT, word_t'({$random(seed)} % 320));
        write_and_track(XR_VID_RIGHT, word_t'(m_left + {$random(seed)} % 400));
        write_and_track(XR_VID_TOP, word_t'({$random(seed)} % 240));
        write_and_track(XR_VID_BOTTOM, word_t'(m_top + {$random(seed)} % 300));
        cb = $random(seed);
        if (cb == m_border) cb = ~cb;
        write_and_track(XR_PA_GFX_CTRL, {cb, 1'b0, 7'b0000000});
        check_window_frame("window pixel");

        write_and_track(XR_PA_GFX_CTRL, {cb, 1'b1, 7'b0000000});
        check_window_frame("blanked pixel");

        $display("All tests passed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verilog
verilog/video_timing_pkg.sv
verilog/video_regs_pkg.sv
verilog/video_sync_gen.sv
verilog/video_regs.sv
verilog/video_window.sv
verilog/video_gen.sv
sim/video_gen_tb.sv

// File: Bender.yml
package:
  name: video_gen

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/video_timing_pkg.sv
      - verilog/video_regs_pkg.sv
      - verilog/video_sync_gen.sv
      - verilog/video_regs.sv
      - verilog/video_window.sv
      - verilog/video_gen.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/video_gen_tb.sv
